// ==== include/radio_defines.svh ====
`ifndef RADIO_DEFINES_SVH
`define RADIO_DEFINES_SVH

//////////////////////////////////////////////////////////////////////
// sample word and settings bus widths
//////////////////////////////////////////////////////////////////////
`define RADIO_SMP_W            32      // {i[31:16], q[15:0]}
`define RADIO_SET_ADDR_W       8
`define RADIO_SET_DATA_W       32

//////////////////////////////////////////////////////////////////////
// settings register map
//////////////////////////////////////////////////////////////////////
`define RADIO_SR_FE_OP         8'd0    // front-end op, data[1:0]
`define RADIO_SR_PKT_LEN       8'd1    // samples per packet, data[7:0]
`define RADIO_SR_CLEAR         8'd2    // any write clears overflow

// reset values and buffer sizing
`define RADIO_PKT_LEN_DEFAULT  8'd4
`define RADIO_FIFO_DEPTH_LOG2  3       // 8 words

`endif

// ==== design/radio_pkg.sv ====
`include "radio_defines.svh"

package radio_pkg;

   // front-end operation applied to every accepted sample
   typedef enum logic [1:0] {
      FE_PASS    = 2'd0,   // unchanged
      FE_SWAP_IQ = 2'd1,   // i and q exchanged
      FE_CONJ    = 2'd2,   // q negated, wraps at 16 bits
      FE_MUTE    = 2'd3    // all zero
   } fe_op_e;

   // output port sequencer
   typedef enum logic [1:0] {
      OUT_IDLE      = 2'd0,   // waiting on the buffer
      OUT_TAKE      = 2'd1,   // word latched, buffer acked
      OUT_SEND      = 2'd2,   // o_smp_req up
      OUT_WAIT_DROP = 2'd3    // waiting for outside ack to fall
   } out_state_e;

   // one buffered sample plus its end of packet marker
   typedef struct packed {
      logic                    last;
      logic [`RADIO_SMP_W-1:0] data;
   } smp_word_t;

endpackage

// ==== design/smp_if.sv ====
`include "radio_defines.svh"

// four-phase sample link
// req up with data/last stable, ack up, req down, ack down
interface smp_if;

   logic                    req;    // sender
   logic                    ack;    // receiver
   logic [`RADIO_SMP_W-1:0] data;   // {i, q}
   logic                    last;   // final sample of a packet

   modport producer (
      output req,
      output data,
      output last,
      input  ack
   );

   modport consumer (
      input  req,
      input  data,
      input  last,
      output ack
   );

endinterface

// ==== design/rx_frontend.sv ====
`include "radio_defines.svh"

module rx_frontend
   import radio_pkg::*;
(
   input  logic                         i_clk,        // radio_clk
   input  logic                         i_rst_n,
   input  logic [`RADIO_SMP_W-1:0]      i_rx_data,    // adc word {i, q}
   input  logic                         i_rx_stb,     // one sample per strobe
   input  logic                         i_set_stb,
   input  logic [`RADIO_SET_ADDR_W-1:0] i_set_addr,
   input  logic [`RADIO_SET_DATA_W-1:0] i_set_data,
   output logic                         o_overflow,   // sticky
   smp_if.producer                      o_smp
);

   localparam int HALF_W = `RADIO_SMP_W / 2;

   //////////////////////////////////////////////////////////////////////
   // settings decode
   //////////////////////////////////////////////////////////////////////
   fe_op_e     fe_op;
   logic [7:0] pkt_len;
   logic       set_op;
   logic       set_len;
   logic       set_clr;

   assign set_op  = i_set_stb && (i_set_addr == `RADIO_SR_FE_OP);
   assign set_len = i_set_stb && (i_set_addr == `RADIO_SR_PKT_LEN);
   assign set_clr = i_set_stb && (i_set_addr == `RADIO_SR_CLEAR);

   // new values apply to strobes from the next cycle on
   always_ff @(posedge i_clk) begin
      if (!i_rst_n) begin
         fe_op   <= FE_PASS;
         pkt_len <= `RADIO_PKT_LEN_DEFAULT;
      end else begin
         if (set_op)
            fe_op <= fe_op_e'(i_set_data[1:0]);
         if (set_len)
            pkt_len <= i_set_data[7:0];
      end
   end

   // per-sample operation
   function automatic logic [`RADIO_SMP_W-1:0] fe_apply(
      input fe_op_e                  op,
      input logic [`RADIO_SMP_W-1:0] smp
   );
      logic [HALF_W-1:0] iv;
      logic [HALF_W-1:0] qv;
      iv = smp[`RADIO_SMP_W-1:HALF_W];
      qv = smp[HALF_W-1:0];
      case (op)
         FE_SWAP_IQ: fe_apply = {qv, iv};
         FE_CONJ:    fe_apply = {iv, -qv};   // 0x8000 stays 0x8000
         FE_MUTE:    fe_apply = '0;
         default:    fe_apply = smp;         // pass
      endcase
   endfunction

   //////////////////////////////////////////////////////////////////////
   // holding word and packet count
   //////////////////////////////////////////////////////////////////////
   logic                    hold_full;     // word waiting for the buffer
   logic                    req_q;
   logic                    wait_lo;       // req dropped, ack still up
   logic [`RADIO_SMP_W-1:0] hold_data;
   logic                    hold_last;
   logic [7:0]              pkt_cnt;
   logic [7:0]              cnt_nxt;
   logic                    accept;
   logic                    drop;
   logic                    is_last;

   assign accept  = i_rx_stb && !hold_full;
   assign drop    = i_rx_stb && hold_full;   // radio is never stalled
   assign cnt_nxt = pkt_cnt + 8'd1;
   assign is_last = (cnt_nxt >= pkt_len);

   // only accepted samples count
   always_ff @(posedge i_clk) begin
      if (!i_rst_n)
         pkt_cnt <= '0;
      else if (set_len)
         pkt_cnt <= '0;                       // new length restarts the packet
      else if (accept)
         pkt_cnt <= is_last ? 8'd0 : cnt_nxt;
   end

   always_ff @(posedge i_clk) begin
      if (accept) begin
         hold_data <= fe_apply(fe_op, i_rx_data);
         hold_last <= is_last;
      end
   end

   // four-phase sender, one step per cycle
   always_ff @(posedge i_clk) begin
      if (!i_rst_n) begin
         hold_full <= 1'b0;
         req_q     <= 1'b0;
         wait_lo   <= 1'b0;
      end else if (!hold_full) begin
         hold_full <= i_rx_stb;
      end else if (!req_q && !wait_lo && !o_smp.ack) begin
         req_q <= 1'b1;                       // word out, req up
      end else if (req_q && o_smp.ack) begin
         req_q   <= 1'b0;
         wait_lo <= 1'b1;
      end else if (wait_lo && !o_smp.ack) begin
         wait_lo   <= 1'b0;
         hold_full <= 1'b0;                   // cycle complete, free again
      end
   end

   always_ff @(posedge i_clk) begin
      if (!i_rst_n)
         o_overflow <= 1'b0;
      else if (drop)
         o_overflow <= 1'b1;                  // a drop beats a clear
      else if (set_clr)
         o_overflow <= 1'b0;
   end

   assign o_smp.req  = req_q;
   assign o_smp.data = hold_data;
   assign o_smp.last = hold_last;

   // buffer must have answered before req goes away
   a_req_until_ack: assert property (@(posedge i_clk) disable iff (!i_rst_n)
      $fell(o_smp.req) |-> $past(o_smp.ack))
      else $error("rx_frontend req fell without ack");

endmodule

// ==== design/sample_fifo.sv ====
`include "radio_defines.svh"

module sample_fifo
   import radio_pkg::*;
(
   input  logic    i_clk,     // radio_clk
   input  logic    i_rst_n,
   smp_if.consumer i_wr,      // from the front end
   smp_if.producer o_rd       // to the output stage
);

   localparam int             AW       = `RADIO_FIFO_DEPTH_LOG2;
   localparam int             DEPTH    = 2 ** AW;
   localparam logic [AW:0]    FULL_CNT = (AW + 1)'(DEPTH);

   smp_word_t     mem [DEPTH];
   logic [AW-1:0] wptr;
   logic [AW-1:0] rptr;
   logic [AW:0]   count;      // words stored
   logic          full;
   logic          empty;
   logic          push;
   logic          pop;
   logic          wr_ack;
   logic          rd_req;

   assign full  = (count == FULL_CNT);
   assign empty = (count == '0);

   //////////////////////////////////////////////////////////////////////
   // write side
   //////////////////////////////////////////////////////////////////////
   // ack held back while full, that is the only back-pressure
   assign push = i_wr.req && !wr_ack && !full;

   always_ff @(posedge i_clk) begin
      if (!i_rst_n)
         wr_ack <= 1'b0;
      else if (push)
         wr_ack <= 1'b1;
      else if (!i_wr.req)
         wr_ack <= 1'b0;                      // sender let go
   end

   always_ff @(posedge i_clk) begin
      if (push)
         mem[wptr] <= '{last: i_wr.last, data: i_wr.data};
   end

   //////////////////////////////////////////////////////////////////////
   // read side
   //////////////////////////////////////////////////////////////////////
   assign pop = rd_req && o_rd.ack;

   // next req only once the reader's ack is down again
   always_ff @(posedge i_clk) begin
      if (!i_rst_n)
         rd_req <= 1'b0;
      else if (pop)
         rd_req <= 1'b0;
      else if (!rd_req && !empty && !o_rd.ack)
         rd_req <= 1'b1;
   end

   // head word, steady until the pop moves rptr
   assign o_rd.req  = rd_req;
   assign o_rd.data = mem[rptr].data;
   assign o_rd.last = mem[rptr].last;
   assign i_wr.ack  = wr_ack;

   // pointers and fill level
   always_ff @(posedge i_clk) begin
      if (!i_rst_n) begin
         wptr  <= '0;
         rptr  <= '0;
         count <= '0;
      end else begin
         if (push)
            wptr <= wptr + 1'b1;               // wraps at depth
         if (pop)
            rptr <= rptr + 1'b1;
         case ({push, pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;           // none or both
         endcase
      end
   end

   // a write handshake never starts on a full buffer
   a_no_push_full: assert property (@(posedge i_clk) disable iff (!i_rst_n)
      $rose(i_wr.ack) |-> ($past(count) != FULL_CNT))
      else $error("sample_fifo push while full");

   // reader only acks a word that is really there
   a_no_pop_empty: assert property (@(posedge i_clk) disable iff (!i_rst_n)
      (o_rd.req && o_rd.ack) |-> !empty)
      else $error("sample_fifo pop while empty");

endmodule

// ==== design/stream_out.sv ====
`include "radio_defines.svh"

module stream_out
   import radio_pkg::*;
(
   input  logic                    i_clk,        // radio_clk
   input  logic                    i_rst_n,
   smp_if.consumer                 i_rd,         // from the buffer
   output logic                    o_smp_req,
   output logic [`RADIO_SMP_W-1:0] o_smp_data,
   output logic                    o_smp_last,
   input  logic                    i_smp_ack     // from outside
);

   out_state_e state;
   logic       rd_ack;

   //////////////////////////////////////////////////////////////////////
   // output sequencer
   //////////////////////////////////////////////////////////////////////
   always_ff @(posedge i_clk) begin
      if (!i_rst_n) begin
         state     <= OUT_IDLE;
         rd_ack    <= 1'b0;
         o_smp_req <= 1'b0;
      end else begin
         case (state)
            OUT_IDLE: begin
               if (i_rd.req) begin
                  rd_ack <= 1'b1;              // word latched below
                  state  <= OUT_TAKE;
               end
            end
            OUT_TAKE: begin
               // buffer finishes its side before we go out
               if (!i_rd.req) begin
                  rd_ack    <= 1'b0;
                  o_smp_req <= 1'b1;
                  state     <= OUT_SEND;
               end
            end
            OUT_SEND: begin
               if (i_smp_ack) begin
                  o_smp_req <= 1'b0;
                  state     <= OUT_WAIT_DROP;
               end
            end
            OUT_WAIT_DROP: begin
               if (!i_smp_ack)
                  state <= OUT_IDLE;           // ready for the next word
            end
            default: state <= OUT_IDLE;
         endcase
      end
   end

   // output word register
   always_ff @(posedge i_clk) begin
      if (state == OUT_IDLE && i_rd.req) begin
         o_smp_data <= i_rd.data;
         o_smp_last <= i_rd.last;
      end
   end

   assign i_rd.ack = rd_ack;

   // outside sees one steady word per req
   a_out_stable: assert property (@(posedge i_clk) disable iff (!i_rst_n)
      (o_smp_req && $past(o_smp_req)) |-> ($stable(o_smp_data) && $stable(o_smp_last)))
      else $error("stream_out word changed under req");

endmodule

// ==== design/radio_rx_core.sv ====
`include "radio_defines.svh"

module radio_rx_core (
   input  logic                         i_clk,        // radio_clk
   input  logic                         i_rst_n,
   // adc side
   input  logic [`RADIO_SMP_W-1:0]      i_rx_data,
   input  logic                         i_rx_stb,
   // settings writes
   input  logic                         i_set_stb,
   input  logic [`RADIO_SET_ADDR_W-1:0] i_set_addr,
   input  logic [`RADIO_SET_DATA_W-1:0] i_set_data,
   // four-phase sample port
   output logic                         o_smp_req,
   output logic [`RADIO_SMP_W-1:0]      o_smp_data,
   output logic                         o_smp_last,
   input  logic                         i_smp_ack,
   output logic                         o_overflow
);

   //////////////////////////////////////////////////////////////////////
   // front end -> buffer -> output port
   //////////////////////////////////////////////////////////////////////
   smp_if fe_to_buf ();
   smp_if buf_to_out ();

   rx_frontend u_rx_frontend (
      .i_clk      (i_clk),
      .i_rst_n    (i_rst_n),
      .i_rx_data  (i_rx_data),
      .i_rx_stb   (i_rx_stb),
      .i_set_stb  (i_set_stb),
      .i_set_addr (i_set_addr),
      .i_set_data (i_set_data),
      .o_overflow (o_overflow),
      .o_smp      (fe_to_buf.producer)
   );

   sample_fifo u_sample_fifo (
      .i_clk   (i_clk),
      .i_rst_n (i_rst_n),
      .i_wr    (fe_to_buf.consumer),
      .o_rd    (buf_to_out.producer)
   );

   stream_out u_stream_out (
      .i_clk      (i_clk),
      .i_rst_n    (i_rst_n),
      .i_rd       (buf_to_out.consumer),
      .o_smp_req  (o_smp_req),
      .o_smp_data (o_smp_data),
      .o_smp_last (o_smp_last),
      .i_smp_ack  (i_smp_ack)
   );

endmodule

// ==== verif/tb_radio_rx_core.sv ====
`include "radio_defines.svh"

module tb_radio_rx_core
   import radio_pkg::*;
();

   localparam int DRV      = 1;                               // input skew after posedge
   localparam int CAPACITY = (2 ** `RADIO_FIFO_DEPTH_LOG2) + 2;  // fifo, out reg, holding word

   typedef struct {
      bit                           set_en;
      logic [`RADIO_SET_ADDR_W-1:0] set_addr;
      logic [`RADIO_SET_DATA_W-1:0] set_data;
      logic [`RADIO_SMP_W-1:0]      smp;
      int                           gap;       // cycles to the next strobe
      bit                           hold;      // outside ack withheld
      bit                           ovf_exp;   // o_overflow after this entry
   } entry_t;

   logic                         radio_clk = 1'b0;
   logic                         i_rst_n;
   logic [`RADIO_SMP_W-1:0]      i_rx_data;
   logic                         i_rx_stb;
   logic                         i_set_stb;
   logic [`RADIO_SET_ADDR_W-1:0] i_set_addr;
   logic [`RADIO_SET_DATA_W-1:0] i_set_data;
   logic                         o_smp_req;
   logic [`RADIO_SMP_W-1:0]      o_smp_data;
   logic                         o_smp_last;
   logic                         i_smp_ack;
   logic                         o_overflow;

   entry_t                  tbl[$];
   logic [`RADIO_SMP_W:0]   exp_q[$];        // {last, data} in output order
   logic [`RADIO_SMP_W:0]   exp_w;
   int                      seed = 32'h0db9_db7c;
   int                      n_checks;
   int                      n_errors;
   int                      n_accepted;
   int                      n_dropped;
   int                      n_held;          // accepted since ack was withheld
   int                      cycles;
   int                      cycle_limit;
   bit                      ack_hold;
   bit                      prev_req;
   bit                      prev_ack;
   logic [1:0]              m_op;            // model of the settings registers
   int                      m_len;
   int                      m_cnt;

   always #50 radio_clk = ~radio_clk;

   radio_rx_core dut (
      .i_clk      (radio_clk),
      .i_rst_n    (i_rst_n),
      .i_rx_data  (i_rx_data),
      .i_rx_stb   (i_rx_stb),
      .i_set_stb  (i_set_stb),
      .i_set_addr (i_set_addr),
      .i_set_data (i_set_data),
      .o_smp_req  (o_smp_req),
      .o_smp_data (o_smp_data),
      .o_smp_last (o_smp_last),
      .i_smp_ack  (i_smp_ack),
      .o_overflow (o_overflow)
   );

   //////////////////////////////////////////////////////////////////////
   // checks and reference model
   //////////////////////////////////////////////////////////////////////
   function automatic void compare_hex(input string name, input logic [31:0] got,
                                       input logic [31:0] exp);
      n_checks++;
      assert (got === exp) else begin
         n_errors++;
         $display("** Error %s got %h expected %h at %0t", name, got, exp, $time);
      end
   endfunction

   function automatic void require_true(input bit ok, input string what);
      n_checks++;
      assert (ok) else begin
         n_errors++;
         $display("%s at %0t", what, $time);
      end
   endfunction

   // front-end ops as the register map defines them
   function automatic logic [31:0] op_result(input logic [1:0] op, input logic [31:0] s);
      logic [15:0] i_part;
      logic [15:0] q_part;
      i_part = s[31:16];
      q_part = s[15:0];
      case (op)
         FE_PASS:    return s;
         FE_SWAP_IQ: return {q_part, i_part};
         FE_CONJ:    return {i_part, 16'(~q_part + 16'd1)};   // two's complement, wraps
         default:    return 32'h0;                           // mute
      endcase
   endfunction

   // with ack withheld the pipeline takes CAPACITY words, then strobes are lost
   function automatic void model_sample(input logic [31:0] s, input bit held);
      bit last;
      if (!held || n_held < CAPACITY) begin
         m_cnt++;
         last = (m_cnt == m_len);             // every m_len-th accepted sample
         if (last)
            m_cnt = 0;
         exp_q.push_back({last, op_result(m_op, s)});
         n_accepted++;
         if (held)
            n_held++;
      end else begin
         n_dropped++;                         // strobe lost, not counted
      end
   endfunction

   function automatic void model_setting(input entry_t e);
      if (e.set_addr == `RADIO_SR_FE_OP)
         m_op = e.set_data[1:0];
      else if (e.set_addr == `RADIO_SR_PKT_LEN) begin
         m_len = e.set_data[7:0];
         m_cnt = 0;                           // count restarts on new length
      end
   endfunction

   function automatic void add_entry(input bit set_en, input logic [7:0] addr,
                                     input logic [31:0] data, input logic [31:0] smp,
                                     input int gap, input bit hold, input bit ovf_exp);
      entry_t e;
      e = '{set_en, addr, data, smp, gap, hold, ovf_exp};
      tbl.push_back(e);
   endfunction

   //////////////////////////////////////////////////////////////////////
   // stimulus table
   //////////////////////////////////////////////////////////////////////
   task automatic build_table();
      int k;
      for (k = 0; k < 6; k++)
         add_entry(0, 0, 0, $random(seed), 8, 0, 0);   // pass, length 4
      add_entry(1, `RADIO_SR_FE_OP, FE_SWAP_IQ, 32'h1234_abcd, 8, 0, 0);
      add_entry(0, 0, 0, 32'h8000_7fff, 8, 0, 0);
      add_entry(1, `RADIO_SR_FE_OP, FE_CONJ, 32'h0102_8000, 8, 0, 0);  // q stays 8000
      add_entry(0, 0, 0, 32'hffff_0001, 8, 0, 0);
      add_entry(0, 0, 0, 32'h5555_0000, 8, 0, 0);
      add_entry(1, `RADIO_SR_FE_OP, FE_MUTE, 32'hdead_beef, 8, 0, 0);
      add_entry(1, `RADIO_SR_FE_OP, FE_PASS, 32'hcafe_f00d, 8, 0, 0);
      add_entry(1, `RADIO_SR_PKT_LEN, 32'd3, $random(seed), 8, 0, 0);
      for (k = 0; k < 6; k++)
         add_entry(0, 0, 0, $random(seed), 8, 0, 0);   // last every third
      // ack withheld, the last two strobes find no room
      for (k = 0; k < CAPACITY + 2; k++)
         add_entry(0, 0, 0, $random(seed), 8, 1, k >= CAPACITY);
      add_entry(1, `RADIO_SR_CLEAR, 0, $random(seed), 8, 0, 0);
      for (k = 0; k < 3; k++)
         add_entry(0, 0, 0, $random(seed), 8, 0, 0);
   endtask

   task automatic wait_drain();
      while (exp_q.size() != 0)
         @(posedge radio_clk);
   endtask

   task automatic apply_entry(input entry_t e);
      if (e.hold != ack_hold) begin
         if (e.hold) begin
            wait_drain();                     // overflow run starts empty
            n_held = 0;
         end
         @(posedge radio_clk);
         #DRV;
         ack_hold = e.hold;
         if (!e.hold)
            wait_drain();
      end
      @(posedge radio_clk);
      #DRV;
      if (e.set_en) begin
         i_set_stb  = 1'b1;
         i_set_addr = e.set_addr;
         i_set_data = e.set_data;
         model_setting(e);
         @(posedge radio_clk);
         #DRV;
         i_set_stb = 1'b0;
      end
      i_rx_data = e.smp;
      i_rx_stb  = 1'b1;
      model_sample(e.smp, e.hold);
      @(posedge radio_clk);
      #DRV;
      i_rx_stb = 1'b0;
      repeat (e.gap - 2) @(posedge radio_clk);
      @(negedge radio_clk);
      compare_hex("o_overflow", o_overflow, e.ovf_exp);
   endtask

   //////////////////////////////////////////////////////////////////////
   // outside receiver, random ack delay
   //////////////////////////////////////////////////////////////////////
   initial begin
      int dly;
      forever begin
         @(negedge radio_clk);
         if (o_smp_req && !ack_hold) begin
            dly = 1 + ($unsigned($random(seed)) % 3);
            repeat (dly) @(posedge radio_clk);
            #DRV;
            i_smp_ack = 1'b1;
            do @(negedge radio_clk); while (o_smp_req);
            @(posedge radio_clk);
            #DRV;
            i_smp_ack = 1'b0;
         end
      end
   end

   // output monitor, data checked on each req rise
   always @(negedge radio_clk) begin
      if (i_rst_n) begin
         if (o_smp_req && !prev_req) begin
            require_true(!prev_ack, "o_smp_req rose while i_smp_ack was still high");
            require_true(exp_q.size() != 0, "output word arrived with no sample pending");
            if (exp_q.size() != 0) begin
               exp_w = exp_q.pop_front();
               compare_hex("o_smp_data", o_smp_data, exp_w[`RADIO_SMP_W-1:0]);
               compare_hex("o_smp_last", o_smp_last, exp_w[`RADIO_SMP_W]);
            end
         end
         if (!o_smp_req && prev_req)
            require_true(prev_ack, "o_smp_req fell before i_smp_ack rose");
      end
      prev_req = o_smp_req;
      prev_ack = i_smp_ack;
   end

   // run limit from the table length
   always @(posedge radio_clk) begin
      cycles <= cycles + 1;
      if (cycle_limit != 0 && cycles >= cycle_limit) begin
         $display("timeout after %0d cycles, output words stopped arriving", cycles);
         $display("Simulation failed");
         $finish;
      end
   end

   //////////////////////////////////////////////////////////////////////
   // main sequence
   //////////////////////////////////////////////////////////////////////
   initial begin
      i_rst_n    = 1'b0;
      i_rx_data  = '0;
      i_rx_stb   = 1'b0;
      i_set_stb  = 1'b0;
      i_set_addr = '0;
      i_set_data = '0;
      i_smp_ack  = 1'b0;
      ack_hold   = 1'b0;
      n_held     = 0;
      m_op       = FE_PASS;
      m_len      = `RADIO_PKT_LEN_DEFAULT;
      m_cnt      = 0;
      build_table();
      cycle_limit = 40 * tbl.size();
      repeat (5) @(posedge radio_clk);
      #DRV;
      i_rst_n = 1'b1;
      @(negedge radio_clk);
      compare_hex("o_smp_req", o_smp_req, 1'b0);     // idle after reset
      compare_hex("o_overflow", o_overflow, 1'b0);
      foreach (tbl[n])
         apply_entry(tbl[n]);
      wait_drain();
      repeat (4) @(posedge radio_clk);                // last handshake closes
      $display("checks %0d, errors %0d, accepted %0d, dropped %0d",
               n_checks, n_errors, n_accepted, n_dropped);
      if (n_errors == 0)
         $display("Simulation completed successfully");
      else
         $display("Simulation failed");
      $finish;
   end

endmodule

// ==== vlog.f ====
+incdir+include
design/radio_pkg.sv
design/smp_if.sv
design/rx_frontend.sv
design/sample_fifo.sv
design/stream_out.sv
design/radio_rx_core.sv
verif/tb_radio_rx_core.sv

// ==== run.sh ====
#!/bin/sh
# build the rx core testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
   --top-module tb_radio_rx_core \
   -f vlog.f \
   -o tb_radio_rx_core

out=$(./obj_dir/tb_radio_rx_core)
echo "$out"

# pass only when the testbench printed its pass line
echo "$out" | grep -q "^Simulation completed successfully$"
